// File: source/ls_pkg.sv
package ls_pkg;

    // data and instruction widths
    localparam int XLEN    = 64;
    localparam int INSTR_W = 32;

    // major opcodes, instruction bits 6..2
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;

    // funct3 of loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LD  = 3'b011,
        LBU = 3'b100,
        LHU = 3'b101,
        LWU = 3'b110
    } mem_op_e;

    // stores reuse the load encodings of the same size
    localparam mem_op_e SB = LB;
    localparam mem_op_e SH = LH;
    localparam mem_op_e SW = LW;
    localparam mem_op_e SD = LD;

    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_LOAD  = 2'd1,
        KIND_STORE = 2'd2
    } ls_kind_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        RD_SETUP  = 3'd1,
        RD_ACCESS = 3'd2,
        WR_SETUP  = 3'd3,
        WR_ACCESS = 3'd4,
        DONE      = 3'd5
    } ls_state_e;

    typedef struct packed {
        ls_kind_e          kind;
        mem_op_e           op;
        logic [XLEN-1:0]   addr;
        logic [XLEN-1:0]   wdata;
        logic              misaligned;
    } ls_req_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [XLEN-1:0]   paddr;
        logic [XLEN-1:0]   pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [XLEN-1:0]   prdata;
        logic              pready;
    } apb_rsp_t;

    typedef struct packed {
        logic              valid;
        logic              error;
        logic [XLEN-1:0]   result;
    } ls_rsp_t;

endpackage

// File: source/ls_decode.sv
module ls_decode (
    input  logic [ls_pkg::INSTR_W-1:0] instr_i,
    input  logic [ls_pkg::XLEN-1:0]    addr_i,
    input  logic [ls_pkg::XLEN-1:0]    wdata_i,
    output ls_pkg::ls_req_t            req_o
);
    import ls_pkg::*;

    logic [4:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr_i[6:2];
    assign funct3 = instr_i[14:12];

    always_comb begin
        req_o       = '0;
        req_o.kind  = KIND_NONE;
        req_o.op    = LB;
        req_o.addr  = addr_i;
        req_o.wdata = wdata_i;

        // funct3 111 is not a load, and stores only use 000..011
        if (opcode == OPC_LOAD && funct3 != 3'b111) begin
            req_o.kind = KIND_LOAD;
        end else if (opcode == OPC_STORE && !funct3[2]) begin
            req_o.kind = KIND_STORE;
        end

        if (req_o.kind != KIND_NONE) begin
            req_o.op = mem_op_e'(funct3);
            // access size sits in the low two funct3 bits
            case (funct3[1:0])
                2'b00:   req_o.misaligned = 1'b0;
                2'b01:   req_o.misaligned = addr_i[0];
                2'b10:   req_o.misaligned = |addr_i[1:0];
                default: req_o.misaligned = |addr_i[2:0];
            endcase
        end
    end

endmodule

// File: source/ls_lane.sv
module ls_lane (
    input  ls_pkg::mem_op_e          op_i,
    input  logic [2:0]               offset_i,
    input  logic [ls_pkg::XLEN-1:0]  rdata_i,
    input  logic [ls_pkg::XLEN-1:0]  wdata_i,
    output logic [ls_pkg::XLEN-1:0]  load_o,
    output logic [ls_pkg::XLEN-1:0]  merge_o
);
    import ls_pkg::*;

    logic [5:0]      shamt;
    logic [XLEN-1:0] rsh;
    logic [XLEN-1:0] wsh;
    logic [7:0]      size_mask;
    logic [7:0]      byte_en;
    logic [XLEN-1:0] bit_mask;

    // byte offset as a bit shift
    assign shamt = {offset_i, 3'b000};

    // addressed lane moved down to bit 0
    assign rsh = rdata_i >> shamt;

    always_comb begin
        case (op_i)
            LB:      load_o = {{(XLEN-8){rsh[7]}}, rsh[7:0]};
            LH:      load_o = {{(XLEN-16){rsh[15]}}, rsh[15:0]};
            LW:      load_o = {{(XLEN-32){rsh[31]}}, rsh[31:0]};
            LBU:     load_o = {{(XLEN-8){1'b0}}, rsh[7:0]};
            LHU:     load_o = {{(XLEN-16){1'b0}}, rsh[15:0]};
            LWU:     load_o = {{(XLEN-32){1'b0}}, rsh[31:0]};
            default: load_o = rdata_i;
        endcase
    end

    // store size, SB/SH/SW/SD share the low funct3 bits with loads
    always_comb begin
        case (op_i[1:0])
            2'b00:   size_mask = 8'h01;
            2'b01:   size_mask = 8'h03;
            2'b10:   size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    // aligned accesses never shift enables past byte 7
    assign byte_en = size_mask << offset_i;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            bit_mask[8*i +: 8] = {8{byte_en[i]}};
        end
    end

    // store data moved up to the addressed lane
    assign wsh = wdata_i << shamt;

    // untouched bytes keep the old doubleword
    assign merge_o = (rdata_i & ~bit_mask) | (wsh & bit_mask);

endmodule

// File: source/ls_apb_master.sv
module ls_apb_master (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  ls_pkg::ls_req_t   req_i,
    output ls_pkg::apb_req_t  apb_o,
    input  ls_pkg::apb_rsp_t  apb_i,
    output ls_pkg::ls_rsp_t   rsp_o
);
    import ls_pkg::*;

    ls_state_e       state_q;
    ls_state_e       state_d;
    ls_req_t         req_q;
    logic [XLEN-1:0] rdata_q;
    logic [XLEN-1:0] load_val;
    logic [XLEN-1:0] merge_val;
    logic            accept;
    logic            is_load;

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i && req_ready_o;
    assign is_load     = (req_q.kind == KIND_LOAD) && !req_q.misaligned;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    if (req_i.misaligned || req_i.kind == KIND_NONE) begin
                        state_d = DONE;
                    end else if (req_i.kind == KIND_STORE && req_i.op == SD) begin
                        // full doubleword, no old data needed
                        state_d = WR_SETUP;
                    end else begin
                        state_d = RD_SETUP;
                    end
                end
            end
            RD_SETUP:  state_d = RD_ACCESS;
            RD_ACCESS: begin
                if (apb_i.pready) begin
                    // partial stores go on to the merged write
                    state_d = (req_q.kind == KIND_STORE) ? WR_SETUP : DONE;
                end
            end
            WR_SETUP:  state_d = WR_ACCESS;
            WR_ACCESS: begin
                if (apb_i.pready) begin
                    state_d = DONE;
                end
            end
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        // old doubleword, captured at the end of the read
        if (state_q == RD_ACCESS && apb_i.pready) begin
            rdata_q <= apb_i.prdata;
        end
    end

    ls_lane u_lane (
        .op_i     (req_q.op),
        .offset_i (req_q.addr[2:0]),
        .rdata_i  (rdata_q),
        .wdata_i  (req_q.wdata),
        .load_o   (load_val),
        .merge_o  (merge_val)
    );

    always_comb begin
        apb_o.psel    = (state_q == RD_SETUP) || (state_q == RD_ACCESS) ||
                        (state_q == WR_SETUP) || (state_q == WR_ACCESS);
        apb_o.penable = (state_q == RD_ACCESS) || (state_q == WR_ACCESS);
        apb_o.pwrite  = (state_q == WR_SETUP) || (state_q == WR_ACCESS);
        // memory is doubleword organized
        apb_o.paddr   = {req_q.addr[XLEN-1:3], 3'b000};
        apb_o.pwdata  = merge_val;
    end

    always_comb begin
        rsp_o.valid  = (state_q == DONE);
        rsp_o.error  = rsp_o.valid && req_q.misaligned;
        rsp_o.result = (rsp_o.valid && is_load) ? load_val : '0;
    end

endmodule

// File: source/ls_dmem.sv
module ls_dmem #(
    parameter int ADDR_W      = 11,
    parameter int WAIT_STATES = 1
) (
    input  logic              clk,
    input  logic              rst_i,
    input  ls_pkg::apb_req_t  apb_i,
    output ls_pkg::apb_rsp_t  apb_o
);
    import ls_pkg::*;

    localparam int DEPTH = 2 ** (ADDR_W - 3);
    // one bit minimum so zero wait states still builds
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    logic [XLEN-1:0]   mem [DEPTH];
    logic [CNT_W-1:0]  wait_cnt;
    logic [ADDR_W-4:0] idx;
    logic              access;
    logic              ready;

    // upper address bits ignored, addresses wrap
    assign idx    = apb_i.paddr[ADDR_W-1:3];
    assign access = apb_i.psel && apb_i.penable;
    assign ready  = access && (wait_cnt == CNT_W'(WAIT_STATES));

    // counts access cycles spent waiting
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && apb_i.pwrite) begin
            mem[idx] <= apb_i.pwdata;
        end
    end

    always_comb begin
        apb_o.pready = ready;
        apb_o.prdata = ready ? mem[idx] : '0;
    end

endmodule

// File: source/ls_stage.sv
module ls_stage #(
    parameter int ADDR_W      = 11,
    parameter int WAIT_STATES = 1
) (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic                       req_valid_i,
    output logic                       req_ready_o,
    input  logic [ls_pkg::INSTR_W-1:0] instr_i,
    input  logic [ls_pkg::XLEN-1:0]    addr_i,
    input  logic [ls_pkg::XLEN-1:0]    wdata_i,
    output ls_pkg::ls_rsp_t            rsp_o
);
    import ls_pkg::*;

    ls_req_t  dec_req;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    ls_decode u_decode (
        .instr_i (instr_i),
        .addr_i  (addr_i),
        .wdata_i (wdata_i),
        .req_o   (dec_req)
    );

    ls_apb_master u_master (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_i       (dec_req),
        .apb_o       (apb_req),
        .apb_i       (apb_rsp),
        .rsp_o       (rsp_o)
    );

    // data memory on the APB side
    ls_dmem #(
        .ADDR_W      (ADDR_W),
        .WAIT_STATES (WAIT_STATES)
    ) u_dmem (
        .clk   (clk),
        .rst_i (rst_i),
        .apb_i (apb_req),
        .apb_o (apb_rsp)
    );

endmodule

// File: dv/ls_stage_assertions.sv
module ls_stage_assertions #(
    parameter int ADDR_W = 11,
    parameter int W      = 1
) (
    input logic                       clk,
    input logic                       rst_i,
    input logic                       req_valid_i,
    input logic                       req_ready_o,
    input logic [ls_pkg::INSTR_W-1:0] instr_i,
    input logic [ls_pkg::XLEN-1:0]    addr_i,
    input logic [ls_pkg::XLEN-1:0]    wdata_i,
    input ls_pkg::ls_rsp_t            rsp_o,
    input ls_pkg::apb_req_t           apb_req,
    input ls_pkg::apb_rsp_t           apb_rsp
);
    timeunit 1ns;
    timeprecision 1ps;
    import ls_pkg::*;

    logic [XLEN-1:0] shadow [2 ** (ADDR_W - 3)];
    logic            accept;
    logic            seen_req;
    logic            pending;
    logic            no_bus;
    logic            exp_err;
    logic [XLEN-1:0] exp_res;
    int              cnt;
    int              exp_lat;
    int              fails = 0;

    assign accept = req_valid_i && req_ready_o;

    // lane value read straight from the shadow doubleword
    function automatic logic [XLEN-1:0] lane_value(logic [XLEN-1:0] dw, logic [2:0] off,
                                                   logic [2:0] f3);
        logic [XLEN-1:0] v;
        case (f3[1:0])
            2'b00: v = f3[2] ? {56'h0, dw[8*off +: 8]} : {{56{dw[8*off+7]}}, dw[8*off +: 8]};
            2'b01: v = f3[2] ? {48'h0, dw[8*off +: 16]} : {{48{dw[8*off+15]}}, dw[8*off +: 16]};
            2'b10: v = f3[2] ? {32'h0, dw[8*off +: 32]} : {{32{dw[8*off+31]}}, dw[8*off +: 32]};
            default: v = dw;
        endcase
        return v;
    endfunction

    always_ff @(posedge clk) begin
        logic [4:0]      opc;
        logic [2:0]      f3;
        logic [2:0]      off;
        logic [ADDR_W-4:0] idx;
        logic            is_ld;
        logic            is_st;
        logic            mis;
        logic [XLEN-1:0] dw;
        opc   = instr_i[6:2];
        f3    = instr_i[14:12];
        off   = addr_i[2:0];
        idx   = addr_i[ADDR_W-1:3];
        is_ld = (opc == 5'b00000) && (f3 != 3'b111);
        is_st = (opc == 5'b01000) && !f3[2];
        mis   = (f3[1:0] == 2'b01 && off[0]) || (f3[1:0] == 2'b10 && off[1:0] != 0) ||
                (f3[1:0] == 2'b11 && off != 0);
        if (rst_i) begin
            pending  <= 1'b0;
            seen_req <= 1'b0;
        end else if (accept) begin
            seen_req <= 1'b1;
            pending  <= 1'b1;
            cnt      <= 1;
            no_bus   <= !(is_ld || is_st) || mis;
            exp_err  <= (is_ld || is_st) && mis;
            exp_res  <= (is_ld && !mis) ? lane_value(shadow[idx], off, f3) : '0;
            if (!(is_ld || is_st) || mis) begin
                exp_lat <= 1;
            end else if (is_ld || f3[1:0] == 2'b11) begin
                exp_lat <= W + 3;
            end else begin
                exp_lat <= 2 * W + 5;
            end
            if (is_st && !mis) begin
                dw = shadow[idx];
                for (int i = 0; i < (1 << f3[1:0]); i++) begin
                    dw[8*(off+i) +: 8] = wdata_i[8*i +: 8];
                end
                shadow[idx] <= dw;
            end
        end else if (pending) begin
            cnt <= cnt + 1;
            if (rsp_o.valid) begin
                pending <= 1'b0;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst_i)
        !seen_req |-> !rsp_o.valid && !apb_req.psel && !apb_req.penable)
        else begin fails++; $error("Fail %0t: activity before first request", $time); end

    a_latency: assert property (@(posedge clk) disable iff (rst_i)
        pending |-> (rsp_o.valid == (cnt == exp_lat)))
        else begin fails++; $error("Fail %0t: response latency wrong", $time); end

    a_valid_pending: assert property (@(posedge clk) disable iff (rst_i)
        rsp_o.valid |-> pending)
        else begin fails++; $error("Fail %0t: response without request", $time); end

    a_ready_low: assert property (@(posedge clk) disable iff (rst_i)
        pending |-> !req_ready_o)
        else begin fails++; $error("Fail %0t: ready high while busy", $time); end

    a_result: assert property (@(posedge clk) disable iff (rst_i)
        rsp_o.valid |-> rsp_o.result == exp_res && rsp_o.error == exp_err)
        else begin fails++; $error("Fail %0t: result %h expected %h", $time,
                                   rsp_o.result, exp_res); end

    a_no_bus: assert property (@(posedge clk) disable iff (rst_i)
        pending && no_bus |-> !apb_req.psel)
        else begin fails++; $error("Fail %0t: bus access on error request", $time); end

    a_setup_first: assert property (@(posedge clk) disable iff (rst_i)
        apb_req.penable && !$past(apb_req.penable) |-> $past(apb_req.psel) && apb_req.psel)
        else begin fails++; $error("Fail %0t: penable without setup", $time); end

    a_stable: assert property (@(posedge clk) disable iff (rst_i)
        apb_req.psel && !apb_rsp.pready |=> $stable(apb_req.paddr) && $stable(apb_req.pwdata))
        else begin fails++; $error("Fail %0t: address or data changed in transfer", $time); end

endmodule

bind ls_stage ls_stage_assertions #(
    .ADDR_W (ADDR_W),
    .W      (WAIT_STATES)
) u_assert (
    .clk         (clk),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .instr_i     (instr_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .rsp_o       (rsp_o),
    .apb_req     (apb_req),
    .apb_rsp     (apb_rsp)
);

// File: dv/ls_stage_tb.sv
module ls_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import ls_pkg::*;

    localparam int W          = 1;
    localparam int RST_CYC    = 10;
    localparam int N_DIRECTED = 150;
    localparam int N_RANDOM   = 300;
    localparam int LIMIT      = (N_DIRECTED + N_RANDOM) * (2 * W + 6) + RST_CYC + 100;

    localparam logic [4:0] OP_LD  = 5'b00000;
    localparam logic [4:0] OP_ST  = 5'b01000;
    localparam logic [4:0] OP_ALU = 5'b01100;

    logic               clk;
    logic               rst_i;
    logic               req_valid_i;
    logic               req_ready_o;
    logic [INSTR_W-1:0] instr_i;
    logic [XLEN-1:0]    addr_i;
    logic [XLEN-1:0]    wdata_i;
    ls_rsp_t            rsp_o;
    int                 cycles;
    int                 seed;

    ls_stage DUT (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .instr_i     (instr_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rsp_o       (rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit and first assertion failure
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("ERRORS FOUND");
            $fatal(1, "the run timed out after %0d cycles", cycles);
        end else if (DUT.u_assert.fails != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "an assertion failed at %0t", $time);
        end
    end

    function automatic logic [INSTR_W-1:0] encode(logic [4:0] opc, logic [2:0] f3);
        return {17'h0, f3, 5'h0, opc, 2'b11};
    endfunction

    // pattern depends on every address bit
    function automatic logic [XLEN-1:0] fill(logic [XLEN-1:0] a);
        return (a * 64'h9e37_79b9_7f4a_7c15) ^ {a[31:0], a[63:32]};
    endfunction

    task automatic send(logic [4:0] opc, logic [2:0] f3, logic [XLEN-1:0] a,
                        logic [XLEN-1:0] d);
        while (!req_ready_o) begin
            @(posedge clk);
            #1;
        end
        req_valid_i = 1'b1;
        instr_i     = encode(opc, f3);
        addr_i      = a;
        wdata_i     = d;
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    initial begin
        logic [4:0] opc;
        cycles      = 0;
        seed        = 32'h9558bfdf;
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        instr_i     = '0;
        addr_i      = '0;
        wdata_i     = '0;
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(posedge clk);
        #1;

        // every doubleword gets a known value first
        for (int i = 0; i < 64; i++) begin
            send(OP_ST, 3'b011, 64'(i * 8), fill(64'(i * 8)));
        end
        // all load types at every offset including misaligned ones
        for (int f = 0; f < 7; f++) begin
            for (int off = 0; off < 8; off++) begin
                send(OP_LD, 3'(f), 64'(40 + off), '0);
            end
        end
        // partial stores each followed by a full readback
        for (int off = 0; off < 8; off++) begin
            send(OP_ST, 3'b000, 64'(48 + off), 64'(8'h80 + off));
            send(OP_LD, 3'b011, 64'd48, '0);
        end
        for (int off = 0; off < 8; off += 2) begin
            send(OP_ST, 3'b001, 64'(56 + off), 64'hfedc_ba98_7654_8321);
            send(OP_LD, 3'b011, 64'd56, '0);
        end
        for (int off = 0; off < 8; off += 4) begin
            send(OP_ST, 3'b010, 64'(64 + off), 64'h0123_4567_89ab_cdef);
            send(OP_LD, 3'b011, 64'd64, '0);
        end
        send(OP_ALU, 3'b000, 64'd8, '0);
        send(OP_ST, 3'b011, 64'd13, 64'hdead_beef);

        for (int n = 0; n < N_RANDOM; n++) begin
            case ($unsigned($random(seed)) % 5)
                0, 1:    opc = OP_LD;
                2, 3:    opc = OP_ST;
                default: opc = OP_ALU;
            endcase
            send(opc, 3'($random(seed)), 64'($random(seed) & 32'h1ff),
                 {32'($random(seed)), 32'($random(seed))});
        end

        // last response drains
        while (!req_ready_o) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        if (DUT.u_assert.fails != 0) begin
            $display("ERRORS FOUND");
            $fatal(1, "an assertion failed during the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: ls_stage.f
source/ls_pkg.sv
source/ls_decode.sv
source/ls_lane.sv
source/ls_apb_master.sv
source/ls_dmem.sv
source/ls_stage.sv
dv/ls_stage_assertions.sv
dv/ls_stage_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := ls_stage_tb
FILELIST := ls_stage.f
OBJ_DIR  := obj_dir

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
